// File: filelist.f
+incdir+design
design/rv_pkg.sv
design/iq_if.sv
design/instr_mem.sv
design/fetch_unit.sv
design/inst_queue.sv
design/exec_core.sv
design/rv_subsys_top.sv
dv/retire_checker.sv
dv/tb_top.sv

// File: dv/tb_top.sv
`include "rv_defs.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NTESTS = 5;

    logic                   clk;
    logic                   rst_i;
    logic                   run_i;
    logic                   halt_i;
    logic                   imem_we_i;
    logic [`RV_IMEM_AW-1:0] imem_addr_i;
    logic [`RV_XLEN-1:0]    imem_wdata_i;
    logic                   retire_valid_o;
    logic [`RV_XLEN-1:0]    retire_pc_o;
    logic [4:0]             retire_rd_o;
    logic [`RV_XLEN-1:0]    retire_wdata_o;
    logic                   exit_o;
    logic [`RV_XLEN-1:0]    gp_o;

    logic [127:0] cur_name;
    int           errors = 0;
    int           chk_errors;
    bit           timed_out = 0;

    // program table
    logic [127:0] names [NTESTS];
    logic [31:0]  progs [NTESTS][16];
    int           lens  [NTESTS];
    bit           halts [NTESTS];
    logic [31:0]  gps   [NTESTS];

    rv_subsys_top dut (.*);

    retire_checker chk (
        .clk            (clk),
        .rst_i          (rst_i),
        .imem_we_i      (imem_we_i),
        .imem_addr_i    (imem_addr_i),
        .imem_wdata_i   (imem_wdata_i),
        .retire_valid_i (retire_valid_o),
        .retire_pc_i    (retire_pc_o),
        .retire_rd_i    (retire_rd_o),
        .retire_wdata_i (retire_wdata_o),
        .exit_i         (exit_o),
        .test_name_i    (cur_name),
        .error_count_o  (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] itype(input int imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm[11:0], rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    function automatic logic [31:0] btype(input int off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] jtype(input int off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic append_word(input int t, input logic [31:0] w);
        progs[t][lens[t]] = w;
        lens[t]++;
    endtask

    task automatic build_table();
        for (int t = 0; t < NTESTS; t++) begin
            lens[t] = 0;
        end
        // straight-line alu
        names[0] = "alu_basic";
        append_word(0, itype(5, 0, 0, 1));
        append_word(0, itype(-3, 0, 0, 2));
        append_word(0, rtype(7'h00, 2, 1, 0, 3));
        append_word(0, rtype(7'h20, 2, 1, 0, 4));
        append_word(0, rtype(7'h00, 2, 1, 7, 5));
        append_word(0, rtype(7'h00, 2, 1, 6, 6));
        append_word(0, rtype(7'h00, 2, 1, 4, 7));
        append_word(0, utype(20'h12345, 8));
        append_word(0, itype(12'h678, 8, 0, 8));
        append_word(0, rtype(7'h00, 8, 3, 0, 3));
        append_word(0, 32'h0000_0073);
        gps[0] = 32'h1234_567a;
        // taken and not-taken branches, jal link, wrong-path slots set x3
        names[1] = "branch_jal";
        append_word(1, itype(1, 0, 0, 1));
        append_word(1, itype(1, 0, 0, 2));
        append_word(1, btype(8, 2, 1, 0));
        append_word(1, itype(99, 0, 0, 3));
        append_word(1, btype(8, 2, 1, 1));
        append_word(1, itype(7, 0, 0, 3));
        append_word(1, jtype(8, 5));
        append_word(1, itype(55, 0, 0, 3));
        append_word(1, itype(1, 3, 0, 3));
        append_word(1, btype(8, 0, 3, 1));
        append_word(1, itype(0, 0, 0, 3));
        append_word(1, 32'h0000_0073);
        gps[1] = 32'd8;
        names[2] = "x0_write";
        append_word(2, itype(9, 0, 0, 0));
        append_word(2, utype(20'habcde, 0));
        append_word(2, itype(4, 0, 0, 1));
        append_word(2, rtype(7'h00, 1, 0, 0, 3));
        append_word(2, rtype(7'h00, 0, 3, 0, 3));
        append_word(2, 32'h0000_0073);
        gps[2] = 32'd4;
        // same programs again under random back-pressure
        names[3] = "alu_halt";
        names[4] = "branch_halt";
        for (int i = 0; i < 16; i++) begin
            progs[3][i] = progs[0][i];
            progs[4][i] = progs[1][i];
        end
        lens[3]  = lens[0];
        lens[4]  = lens[1];
        gps[3]   = gps[0];
        gps[4]   = gps[1];
        for (int t = 0; t < NTESTS; t++) begin
            halts[t] = (t >= 3);
        end
    endtask

    task automatic run_program(input int t);
        int cycles;
        @(negedge clk);
        cur_name = names[t];
        rst_i    = 1'b1;
        run_i    = 1'b0;
        halt_i   = 1'b0;
        for (int i = 0; i < lens[t]; i++) begin
            @(negedge clk);
            imem_we_i    = 1'b1;
            imem_addr_i  = i[`RV_IMEM_AW-1:0];
            imem_wdata_i = progs[t][i];
        end
        @(negedge clk);
        imem_we_i = 1'b0;
        repeat (5) @(negedge clk);
        rst_i  = 1'b0;
        run_i  = 1'b1;
        cycles = 0;
        while (!exit_o && cycles < 2000) begin
            @(negedge clk);
            cycles++;
            if (halts[t]) begin
                halt_i = ($urandom % 4) != 0;
            end
        end
        if (!exit_o) begin
            $display("test %0s: exit_o never rose within 2000 cycles", names[t]);
            errors++;
            timed_out = 1'b1;
        end else begin
            // idle cycles so the checker sees any late retirement
            repeat (8) @(negedge clk);
            if (gp_o !== gps[t]) begin
                $display("[ERROR] %0s gp_o expected 0x%08h actual 0x%08h",
                         names[t], gps[t], gp_o);
                errors++;
            end
        end
        run_i  = 1'b0;
        halt_i = 1'b0;
    endtask

    initial begin
        void'($urandom(611));
        rst_i        = 1'b1;
        run_i        = 1'b0;
        halt_i       = 1'b0;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        cur_name     = "reset";
        build_table();
        for (int t = 0; t < NTESTS && !timed_out; t++) begin
            run_program(t);
        end
        $display("errors: testbench %0d, checker %0d", errors, chk_errors);
        if (errors == 0 && chk_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: dv/retire_checker.sv
`include "rv_defs.svh"

module retire_checker (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   imem_we_i,
    input  logic [`RV_IMEM_AW-1:0] imem_addr_i,
    input  logic [`RV_XLEN-1:0]    imem_wdata_i,
    input  logic                   retire_valid_i,
    input  logic [`RV_XLEN-1:0]    retire_pc_i,
    input  logic [4:0]             retire_rd_i,
    input  logic [`RV_XLEN-1:0]    retire_wdata_i,
    input  logic                   exit_i,
    input  logic [127:0]           test_name_i,
    output int                     error_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] prog  [2 ** `RV_IMEM_AW];
    logic [31:0] mregs [32];
    logic [31:0] mpc;
    bit          done;
    bit          exit_reported;
    int          errors = 0;

    assign error_count_o = errors;

    task automatic check_field(input string field, input logic [31:0] expv,
                               input logic [31:0] actv);
        if (expv !== actv) begin
            $display("[ERROR] %0s %0s expected 0x%08h actual 0x%08h",
                     test_name_i, field, expv, actv);
            errors++;
        end
    endtask

    // reference ISA step for the instruction at the model pc
    task automatic step_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] op_b;
        logic [31:0] val;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        bit          wr;
        w       = prog[mpc[`RV_IMEM_AW+1:2]];
        a       = mregs[w[19:15]];
        b       = mregs[w[24:20]];
        rd      = w[11:7];
        next_pc = mpc + 32'd4;
        wr      = 1'b0;
        val     = '0;
        op_b    = (w[6:0] == 7'h33) ? b : {{20{w[31]}}, w[31:20]};
        case (w[6:0])
            7'h33, 7'h13: begin
                wr = 1'b1;
                case (w[14:12])
                    3'd0: val = (w[6:0] == 7'h33 && w[30]) ? a - op_b : a + op_b;
                    3'd4: val = a ^ op_b;
                    3'd6: val = a | op_b;
                    3'd7: val = a & op_b;
                    default: wr = 1'b0;
                endcase
            end
            7'h37: begin
                wr  = 1'b1;
                val = {w[31:12], 12'b0};
            end
            7'h63: begin
                if ((w[14:12] == 3'd0 && a == b) || (w[14:12] == 3'd1 && a != b)) begin
                    next_pc = mpc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            7'h6f: begin
                wr      = 1'b1;
                val     = mpc + 32'd4;
                next_pc = mpc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h73: done = 1'b1;
            default: begin
                $display("test %0s: model found unsupported word 0x%08h at pc 0x%08h",
                         test_name_i, w, mpc);
                errors++;
            end
        endcase
        if (rd == 5'd0) begin
            wr = 1'b0;
        end
        check_field("retire pc", mpc, retire_pc_i);
        check_field("retire rd", wr ? 32'(rd) : 32'd0, 32'(retire_rd_i));
        check_field("retire wdata", wr ? val : 32'd0, retire_wdata_i);
        if (wr) begin
            mregs[rd] = val;
        end
        mpc = next_pc;
    endtask

    always @(posedge clk) begin
        if (imem_we_i) begin
            prog[imem_addr_i] = imem_wdata_i;
        end
        if (rst_i) begin
            mpc           = '0;
            done          = 1'b0;
            exit_reported = 1'b0;
            for (int k = 0; k < 32; k++) begin
                mregs[k] = '0;
            end
        end else begin
            if (retire_valid_i && done) begin
                $display("test %0s: an instruction retired after exit_o rose", test_name_i);
                errors++;
            end else if (retire_valid_i) begin
                step_model();
            end
            // exit must come from a retired ecall
            if (exit_i && !done && !exit_reported) begin
                $display("test %0s: exit_o rose before any ECALL retired", test_name_i);
                exit_reported = 1'b1;
                errors++;
            end
        end
    end

endmodule

// File: design/rv_subsys_top.sv
`include "rv_defs.svh"

module rv_subsys_top (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   run_i,
    input  logic                   halt_i,
    input  logic                   imem_we_i,
    input  logic [`RV_IMEM_AW-1:0] imem_addr_i,
    input  logic [`RV_XLEN-1:0]    imem_wdata_i,
    output logic                   retire_valid_o,
    output logic [`RV_XLEN-1:0]    retire_pc_o,
    output logic [4:0]             retire_rd_o,
    output logic [`RV_XLEN-1:0]    retire_wdata_o,
    output logic                   exit_o,
    output logic [`RV_XLEN-1:0]    gp_o
);

    logic                   mem_rd_en;
    logic [`RV_IMEM_AW-1:0] mem_rd_addr;
    logic [`RV_XLEN-1:0]    mem_rd_data;
    logic                   redirect;
    logic [`RV_XLEN-1:0]    redirect_pc;

    iq_push_if push_if ();
    iq_pop_if  pop_if ();

    instr_mem u_imem (
        .clk       (clk),
        .wr_en_i   (imem_we_i),
        .wr_addr_i (imem_addr_i),
        .wr_data_i (imem_wdata_i),
        .rd_en_i   (mem_rd_en),
        .rd_addr_i (mem_rd_addr),
        .rd_data_o (mem_rd_data)
    );

    fetch_unit u_fetch (
        .clk           (clk),
        .rst_i         (rst_i),
        .run_i         (run_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .mem_rd_en_o   (mem_rd_en),
        .mem_rd_addr_o (mem_rd_addr),
        .mem_rd_data_i (mem_rd_data),
        .push_if       (push_if.producer)
    );

    // the redirect doubles as the queue flush
    inst_queue u_iq (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (redirect),
        .push_if (push_if.buffer),
        .pop_if  (pop_if.buffer)
    );

    exec_core u_core (
        .clk            (clk),
        .rst_i          (rst_i),
        .halt_i         (halt_i),
        .pop_if         (pop_if.consumer),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_wdata_o (retire_wdata_o),
        .exit_o         (exit_o),
        .gp_o           (gp_o)
    );

endmodule

// File: design/exec_core.sv
`include "rv_defs.svh"

module exec_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                halt_i,
    iq_pop_if.consumer          pop_if,
    output logic                redirect_o,
    output logic [`RV_XLEN-1:0] redirect_pc_o,
    output logic                retire_valid_o,
    output logic [`RV_XLEN-1:0] retire_pc_o,
    output logic [4:0]          retire_rd_o,
    output logic [`RV_XLEN-1:0] retire_wdata_o,
    output logic                exit_o,
    output logic [`RV_XLEN-1:0] gp_o
);

    localparam int XL = `RV_XLEN;

    inst_t         ins;
    opcode_e       opcode;
    logic [2:0]    funct3;
    logic [XL-1:0] imm_i;
    logic [XL-1:0] imm_b;
    logic [XL-1:0] imm_u;
    logic [XL-1:0] imm_j;
    logic [XL-1:0] rs1_val;
    logic [XL-1:0] rs2_val;
    logic [XL-1:0] alu_b;
    logic [XL-1:0] result;
    logic [XL-1:0] target;
    logic          rd_write;
    logic          taken;
    logic          is_ecall;
    retire_t       ret_d;
    retire_t       ret_q;

    logic [XL-1:0] regs [32];

    assign ins    = pop_if.inst;
    assign opcode = ins.r_fmt.opcode;
    assign funct3 = ins.r_fmt.funct3;

    assign imm_i = {{(XL - 12){ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
    assign imm_b = {{(XL - 12){ins.b_fmt.imm12}}, ins.b_fmt.imm11,
                    ins.b_fmt.imm10_5, ins.b_fmt.imm4_1, 1'b0};
    assign imm_u = {ins.u_fmt.imm31_12, 12'b0};
    assign imm_j = {{(XL - 20){ins.j_fmt.imm20}}, ins.j_fmt.imm19_12,
                    ins.j_fmt.imm11, ins.j_fmt.imm10_1, 1'b0};

    // x0 reads as zero
    assign rs1_val = (ins.r_fmt.rs1 == 5'd0) ? '0 : regs[ins.r_fmt.rs1];
    assign rs2_val = (ins.r_fmt.rs2 == 5'd0) ? '0 : regs[ins.r_fmt.rs2];
    assign alu_b   = (opcode == OP) ? rs2_val : imm_i;

    always_comb begin
        result   = '0;
        target   = pop_if.pc + imm_b;
        rd_write = 1'b0;
        taken    = 1'b0;
        is_ecall = 1'b0;
        case (opcode)
            OP, OP_IMM: begin
                rd_write = 1'b1;
                case (funct3)
                    F3_XOR:  result = rs1_val ^ alu_b;
                    F3_OR:   result = rs1_val | alu_b;
                    F3_AND:  result = rs1_val & alu_b;
                    default: begin
                        // sub only exists in the register form
                        if (opcode == OP && ins.r_fmt.funct7[5]) begin
                            result = rs1_val - alu_b;
                        end else begin
                            result = rs1_val + alu_b;
                        end
                    end
                endcase
            end
            LUI: begin
                rd_write = 1'b1;
                result   = imm_u;
            end
            JAL: begin
                rd_write = 1'b1;
                result   = pop_if.pc + XL'(4);
                target   = pop_if.pc + imm_j;
                taken    = 1'b1;
            end
            BRANCH: begin
                if (funct3 == F3_BEQ) begin
                    taken = (rs1_val == rs2_val);
                end else if (funct3 == F3_BNE) begin
                    taken = (rs1_val != rs2_val);
                end
            end
            SYSTEM: is_ecall = 1'b1;
            default: ;
        endcase
    end

    // stalled for halt, for the redirect bubble and after exit
    assign pop_if.pop = pop_if.valid && !halt_i && !redirect_o && !exit_o;

    assign ret_d.pc    = pop_if.pc;
    assign ret_d.we    = rd_write && (ins.r_fmt.rd != 5'd0);
    assign ret_d.rd    = ret_d.we ? ins.r_fmt.rd : 5'd0;
    assign ret_d.wdata = ret_d.we ? result : '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (pop_if.pop && ret_d.we) begin
            regs[ret_d.rd] <= ret_d.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_valid_o <= 1'b0;
            redirect_o     <= 1'b0;
            exit_o         <= 1'b0;
        end else begin
            retire_valid_o <= pop_if.pop;
            redirect_o     <= pop_if.pop && taken;
            exit_o         <= exit_o || (pop_if.pop && is_ecall);
        end
    end

    always_ff @(posedge clk) begin
        ret_q         <= ret_d;
        redirect_pc_o <= target;
    end

    // ecall retires too, with no register write
    assign retire_pc_o    = ret_q.pc;
    assign retire_rd_o    = ret_q.rd;
    assign retire_wdata_o = ret_q.wdata;
    assign gp_o           = regs[3];

    // the flush leaves no wrong-path entry at the head
    a_redirect_flush: assert property (@(posedge clk) disable iff (rst_i)
        redirect_o |=> !pop_if.valid)
        else $error("queue entry visible in the cycle after a redirect");

endmodule

// File: design/inst_queue.sv
`include "rv_defs.svh"

module inst_queue import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      flush_i,
    iq_push_if.buffer push_if,
    iq_pop_if.buffer  pop_if
);

    localparam int DEPTH = `RV_IQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`RV_XLEN-1:0] pc_q   [DEPTH];
    inst_t               inst_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // flush wins over a push in the same cycle
    assign do_push = push_if.push && !flush_i;
    assign do_pop  = pop_if.pop && !flush_i;

    assign push_if.almost_full = (count >= CNT_W'(DEPTH - 1));
    assign pop_if.valid        = (count != '0);
    assign pop_if.pc           = pc_q[rd_ptr];
    assign pop_if.inst         = inst_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_q[wr_ptr]   <= push_if.pc;
            inst_q[wr_ptr] <= push_if.inst;
        end
    end

    // fetch must respect almost_full across its one pending read
    a_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
        do_push |-> (count != CNT_W'(DEPTH)))
        else $error("instruction queue push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst_i)
        do_pop |-> (count != '0))
        else $error("instruction queue pop while empty");

endmodule

// File: design/fetch_unit.sv
`include "rv_defs.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   run_i,
    input  logic                   redirect_i,
    input  logic [`RV_XLEN-1:0]    redirect_pc_i,
    output logic                   mem_rd_en_o,
    output logic [`RV_IMEM_AW-1:0] mem_rd_addr_o,
    input  logic [`RV_XLEN-1:0]    mem_rd_data_i,
    iq_push_if.producer            push_if
);

    logic [`RV_XLEN-1:0] fetch_pc;
    logic                inflight;
    logic [`RV_XLEN-1:0] inflight_pc;

    // no new read while the queue is nearly full or the flow changes
    assign mem_rd_en_o   = run_i && !push_if.almost_full && !redirect_i;
    assign mem_rd_addr_o = fetch_pc[`RV_IMEM_AW+1:2];

    // returned word goes straight into the queue, dropped on redirect
    assign push_if.push = inflight && !redirect_i;
    assign push_if.pc   = inflight_pc;
    assign push_if.inst = mem_rd_data_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fetch_pc <= '0;
            inflight <= 1'b0;
        end else if (redirect_i) begin
            fetch_pc <= redirect_pc_i;
            inflight <= 1'b0;
        end else if (mem_rd_en_o) begin
            fetch_pc <= fetch_pc + `RV_XLEN'(4);
            inflight <= 1'b1;
        end else begin
            inflight <= 1'b0;
        end
    end

    // pc of the pending read
    always_ff @(posedge clk) begin
        if (mem_rd_en_o) begin
            inflight_pc <= fetch_pc;
        end
    end

endmodule

// File: design/instr_mem.sv
`include "rv_defs.svh"

module instr_mem (
    input  logic                   clk,
    input  logic                   wr_en_i,
    input  logic [`RV_IMEM_AW-1:0] wr_addr_i,
    input  logic [`RV_XLEN-1:0]    wr_data_i,
    input  logic                   rd_en_i,
    input  logic [`RV_IMEM_AW-1:0] rd_addr_i,
    output logic [`RV_XLEN-1:0]    rd_data_o
);

    localparam int WORDS = 2 ** `RV_IMEM_AW;

    logic [`RV_XLEN-1:0] mem [WORDS];

    // program load port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, data one cycle after rd_en_i
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// File: design/iq_if.sv
`include "rv_defs.svh"

// fetch side of the instruction queue
interface iq_push_if import rv_pkg::*; ();
    logic                push;
    logic [`RV_XLEN-1:0] pc;
    inst_t               inst;
    logic                almost_full;

    modport producer (output push, output pc, output inst, input almost_full);
    modport buffer (input push, input pc, input inst, output almost_full);
endinterface

// execution side of the instruction queue
interface iq_pop_if import rv_pkg::*; ();
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    inst_t               inst;
    logic                pop;

    modport buffer (output valid, output pc, output inst, input pop);
    modport consumer (input valid, input pc, input inst, output pop);
endinterface

// File: design/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 for OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_alu_e;

    // funct3 for BRANCH
    typedef enum logic [2:0] {
        F3_BEQ = 3'b000,
        F3_BNE = 3'b001
    } funct3_br_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // one instruction word, seen through each encoding
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

    // rd and wdata read as zero when we is low
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] wdata;
        logic                we;
    } retire_t;

endpackage

// File: design/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data and pc width
`define RV_XLEN 32

// instruction memory word address width, 64 words
`define RV_IMEM_AW 6

// instruction queue entries
`define RV_IQ_DEPTH 4

`endif
